// File: logic/clint_pkg.sv
`default_nettype none

package clint_pkg;

	// register word width, the counter is defined at 64 bits only
	localparam int DATA_WIDTH = 64;

	// register offsets from the base address
	localparam logic [63:0] MSIP_OFFSET     = 64'h0000_0000_0000_0000;
	localparam logic [63:0] MTIMECMP_OFFSET = 64'h0000_0000_0000_4000;
	localparam logic [63:0] MTIME_OFFSET    = 64'h0000_0000_0000_bff8;

	// compare register comes up with the interrupt out of reach
	localparam logic [DATA_WIDTH-1:0] MTIMECMP_RESET = {DATA_WIDTH{1'b1}};

	// bus response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: logic/clint_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module clint_bus_decode #(
	parameter int ADDR_WIDTH = 64,
	parameter logic [ADDR_WIDTH-1:0] CLINT_BASE = 'h2000000
) (
	input  logic clk,
	input  logic reset,
	input  logic [ADDR_WIDTH-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [clint_pkg::DATA_WIDTH-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	input  logic wr_busy,
	input  logic rd_busy,
	output logic wr_en,
	output logic rd_en,
	output logic sel_msip,
	output logic sel_mtimecmp,
	output logic sel_mtime,
	output logic addr_hit,
	output logic [clint_pkg::DATA_WIDTH-1:0] wr_data
);

	// absolute register addresses, cut to the bus width
	localparam logic [ADDR_WIDTH-1:0] MSIP_ADDR =
		ADDR_WIDTH'(CLINT_BASE + clint_pkg::MSIP_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] MTIMECMP_ADDR =
		ADDR_WIDTH'(CLINT_BASE + clint_pkg::MTIMECMP_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] MTIME_ADDR =
		ADDR_WIDTH'(CLINT_BASE + clint_pkg::MTIME_OFFSET);

	logic aw_pulse;       // shared by awready and wready
	logic ar_pulse;
	logic aw_hs;
	logic ar_hs;
	logic rd_pend;        // read waiting behind a write pulse
	logic rd_go;
	logic [ADDR_WIDTH-1:0] acc_addr;   // address of the access being pulsed
	logic [ADDR_WIDTH-1:0] rd_addr_q;

	assign awready = aw_pulse;
	assign wready  = aw_pulse;
	assign arready = ar_pulse;

	assign aw_hs = aw_pulse && awvalid && wvalid;
	assign ar_hs = ar_pulse && arvalid;

	// a write pulse takes the slot, the read goes one cycle later
	assign rd_go = (ar_hs || rd_pend) && !aw_hs;

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_pulse <= 1'b0;
			ar_pulse <= 1'b0;
			wr_en    <= 1'b0;
			rd_en    <= 1'b0;
			rd_pend  <= 1'b0;
		end else begin
			// one-cycle ready, never twice in a row for the same request
			aw_pulse <= awvalid && wvalid && !aw_pulse && !wr_busy;
			ar_pulse <= arvalid && !ar_pulse && !rd_pend && !rd_busy;
			wr_en    <= aw_hs;
			rd_en    <= rd_go;
			rd_pend  <= (ar_hs || rd_pend) && aw_hs;
		end
	end

	// address and data capture
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			acc_addr <= awaddr;
			wr_data  <= wdata;
		end else if (rd_go) begin
			acc_addr <= ar_hs ? araddr : rd_addr_q;
		end
		if (ar_hs)
			rd_addr_q <= araddr;   // kept in case the read is deferred
	end

	// one comparator path for both directions
	always_comb begin
		sel_msip     = (acc_addr == MSIP_ADDR);
		sel_mtimecmp = (acc_addr == MTIMECMP_ADDR);
		sel_mtime    = (acc_addr == MTIME_ADDR);
		addr_hit     = sel_msip || sel_mtimecmp || sel_mtime;
	end

endmodule

`default_nettype wire

// File: logic/clint_timer_core.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer_core (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  logic rd_en,
	input  logic sel_msip,
	input  logic sel_mtimecmp,
	input  logic sel_mtime,
	input  logic [clint_pkg::DATA_WIDTH-1:0] wr_data,
	output logic [clint_pkg::DATA_WIDTH-1:0] reg_rdata,
	output logic [clint_pkg::DATA_WIDTH-1:0] mtime,
	output logic timer_irq,
	output logic soft_irq
);

	localparam int DW = clint_pkg::DATA_WIDTH;

	logic [DW-1:0] mtimecmp;
	logic msip;
	logic wr_mtime;
	logic wr_mtimecmp;
	logic wr_msip;

	assign wr_mtime    = wr_en && sel_mtime;
	assign wr_mtimecmp = wr_en && sel_mtimecmp;
	assign wr_msip     = wr_en && sel_msip;

	// counter runs every cycle, a write replaces the increment
	always_ff @(posedge clk) begin
		if (reset) begin
			mtime <= '0;
		end else if (wr_mtime) begin
			mtime <= wr_data;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mtimecmp <= clint_pkg::MTIMECMP_RESET;
			msip     <= 1'b0;
		end else begin
			if (wr_mtimecmp)
				mtimecmp <= wr_data;
			if (wr_msip)
				msip <= wr_data[0];   // upper bits are hardwired zero
		end
	end

	// level interrupt, one cycle behind the compare
	always_ff @(posedge clk) begin
		if (reset)
			timer_irq <= 1'b0;
		else
			timer_irq <= (mtime >= mtimecmp);
	end

	assign soft_irq = msip;

	// read mux, only meaningful in the rd_en cycle
	always_comb begin
		reg_rdata = '0;
		if (rd_en) begin
			if (sel_mtime)
				reg_rdata = mtime;
			else if (sel_mtimecmp)
				reg_rdata = mtimecmp;
			else if (sel_msip)
				reg_rdata = {{(DW-1){1'b0}}, msip};
		end
	end

endmodule

`default_nettype wire

// File: logic/clint_response.sv
`timescale 1ns/1ps
`default_nettype none

module clint_response (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  logic rd_en,
	input  logic addr_hit,
	input  logic [clint_pkg::DATA_WIDTH-1:0] reg_rdata,
	input  logic bready,
	input  logic rready,
	output logic bvalid,
	output logic [1:0] bresp,
	output logic rvalid,
	output logic [clint_pkg::DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic wr_busy,
	output logic rd_busy
);

	logic bvalid_q;          // write response still held
	logic [1:0] bresp_q;
	logic [1:0] hit_resp;

	// only one access pulse per cycle, so one code serves both channels
	assign hit_resp = addr_hit ? clint_pkg::RESP_OKAY : clint_pkg::RESP_SLVERR;

	// write response shows up in the pulse cycle itself
	assign bvalid = wr_en || bvalid_q;
	assign bresp  = wr_en ? hit_resp : bresp_q;

	assign wr_busy = wr_en || bvalid_q;
	assign rd_busy = rd_en || rvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid_q <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			// write channel
			if (wr_en)
				bvalid_q <= !bready;   // taken at once if the master is ready
			else if (bready)
				bvalid_q <= 1'b0;

			// read channel, rvalid follows the capture by one cycle
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// response payload, held while the flags are up
	always_ff @(posedge clk) begin
		if (wr_en)
			bresp_q <= hit_resp;
		if (rd_en) begin
			rdata <= reg_rdata;   // already zero for an unmapped address
			rresp <= hit_resp;
		end
	end

endmodule

`default_nettype wire

// File: logic/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
	parameter int ADDR_WIDTH = 64,
	parameter logic [ADDR_WIDTH-1:0] CLINT_BASE = 'h2000000
) (
	input  logic clk,
	input  logic reset,
	input  logic [ADDR_WIDTH-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [clint_pkg::DATA_WIDTH-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input  logic bready,
	input  logic [ADDR_WIDTH-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [clint_pkg::DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	input  logic rready,
	output logic timer_irq,
	output logic soft_irq,
	output logic [clint_pkg::DATA_WIDTH-1:0] mtime
);

	logic wr_en;
	logic rd_en;
	logic sel_msip;
	logic sel_mtimecmp;
	logic sel_mtime;
	logic addr_hit;
	logic wr_busy;
	logic rd_busy;
	logic [clint_pkg::DATA_WIDTH-1:0] wr_data;
	logic [clint_pkg::DATA_WIDTH-1:0] reg_rdata;

	// bus acceptance and address decode
	clint_bus_decode #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.CLINT_BASE (CLINT_BASE)
	) u_decode (
		.clk          (clk),
		.reset        (reset),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wvalid       (wvalid),
		.wready       (wready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.wr_busy      (wr_busy),
		.rd_busy      (rd_busy),
		.wr_en        (wr_en),
		.rd_en        (rd_en),
		.sel_msip     (sel_msip),
		.sel_mtimecmp (sel_mtimecmp),
		.sel_mtime    (sel_mtime),
		.addr_hit     (addr_hit),
		.wr_data      (wr_data)
	);

	// timer registers and interrupts
	clint_timer_core u_core (
		.clk          (clk),
		.reset        (reset),
		.wr_en        (wr_en),
		.rd_en        (rd_en),
		.sel_msip     (sel_msip),
		.sel_mtimecmp (sel_mtimecmp),
		.sel_mtime    (sel_mtime),
		.wr_data      (wr_data),
		.reg_rdata    (reg_rdata),
		.mtime        (mtime),
		.timer_irq    (timer_irq),
		.soft_irq     (soft_irq)
	);

	clint_response u_response (
		.clk       (clk),
		.reset     (reset),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.addr_hit  (addr_hit),
		.reg_rdata (reg_rdata),
		.bready    (bready),
		.rready    (rready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.rresp     (rresp),
		.wr_busy   (wr_busy),
		.rd_busy   (rd_busy)
	);

endmodule

`default_nettype wire

// File: bench/clint_timer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer_tb;

	localparam int ADDR_WIDTH = 64;
	localparam logic [ADDR_WIDTH-1:0] CLINT_BASE = 'h2000000;
	localparam int NUM_TX = 400;
	localparam int RESET_CYCLES = 16;
	localparam int LIMIT = 20 * NUM_TX + RESET_CYCLES;
	localparam logic [ADDR_WIDTH-1:0] MSIP_ADDR = ADDR_WIDTH'(CLINT_BASE + clint_pkg::MSIP_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] MTIMECMP_ADDR =
		ADDR_WIDTH'(CLINT_BASE + clint_pkg::MTIMECMP_OFFSET);
	localparam logic [ADDR_WIDTH-1:0] MTIME_ADDR = ADDR_WIDTH'(CLINT_BASE + clint_pkg::MTIME_OFFSET);

	logic clk, reset;
	logic [ADDR_WIDTH-1:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [63:0] wdata, rdata, mtime;
	logic awready, wready, bvalid, arready, rvalid, timer_irq, soft_irq;
	logic [1:0] bresp, rresp;

	logic [63:0] rng;
	int cycles;
	logic m_msip;                  // model registers as the DUT holds them
	logic [63:0] m_cmp;
	logic [63:0] mt_next;          // expected mtime port next cycle
	logic mt_valid, irq_exp, irq_valid;
	logic b_hold, r_hold;          // response was stalled last cycle
	logic [1:0] bresp_d, rresp_d;
	logic [63:0] rdata_d;
	logic wr_out, rd_out;          // request accepted and response still owed

	clint_timer #(.ADDR_WIDTH(ADDR_WIDTH), .CLINT_BASE(CLINT_BASE)) u_clint_timer (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [63:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 7);
		rng = rng ^ (rng << 17);
		return rng;
	endfunction

	function automatic logic [1:0] expected_resp(input logic [ADDR_WIDTH-1:0] addr);
		if (addr == MSIP_ADDR || addr == MTIMECMP_ADDR || addr == MTIME_ADDR)
			return clint_pkg::RESP_OKAY;
		return clint_pkg::RESP_SLVERR;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] unmapped_addr();
		logic [63:0] r;
		logic [ADDR_WIDTH-1:0] a;
		r = next_rand();
		// half near the register block and half anywhere
		a = r[63] ? ADDR_WIDTH'(CLINT_BASE + (r & 64'hfff8)) : ADDR_WIDTH'(r);
		if (expected_resp(a) == clint_pkg::RESP_OKAY)
			a = a + ADDR_WIDTH'(8);
		return a;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h got %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	// one clock and the checks that hold in every cycle
	task automatic tick();
		@(posedge clk);
		cycles++;
		if (cycles > LIMIT)
			stop_run("simulation timed out waiting for a bus handshake");
		if (!reset) begin
			if (mt_valid)
				check_value("mtime", mt_next, mtime);
			if (irq_valid)
				check_value("timer_irq", 64'(irq_exp), 64'(timer_irq));
			check_value("soft_irq", 64'(m_msip), 64'(soft_irq));
			if (b_hold) begin
				check_value("bvalid", 64'd1, 64'(bvalid));
				check_value("bresp", 64'(bresp_d), 64'(bresp));
			end
			if (r_hold) begin
				check_value("rvalid", 64'd1, 64'(rvalid));
				check_value("rdata", rdata_d, rdata);
				check_value("rresp", 64'(rresp_d), 64'(rresp));
			end
			if (bvalid && !wr_out)
				stop_run("write response without an accepted write");
			if (rvalid && !rd_out)
				stop_run("read response without an accepted read");
		end
		mt_next = mtime + 64'd1;
		mt_valid = !reset;
		irq_exp = (mtime >= m_cmp);   // irq is one cycle behind the compare
		irq_valid = !reset;
		b_hold = bvalid && !bready;
		r_hold = rvalid && !rready;
		bresp_d = bresp;
		rresp_d = rresp;
		rdata_d = rdata;
	endtask

	task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input logic [63:0] data,
			input int hold);
		int held;
		logic seen;
		held = 0;
		seen = 1'b0;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= (hold == 0);
		do tick(); while (!awready);
		check_value("wready", 64'd1, 64'(wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		wr_out = 1'b1;
		while (wr_out) begin
			tick();
			if (bvalid && !seen) begin
				seen = 1'b1;   // register takes the data at the end of this cycle
				if (addr == MSIP_ADDR)
					m_msip = data[0];
				else if (addr == MTIMECMP_ADDR)
					m_cmp = data;
				else if (addr == MTIME_ADDR)
					mt_next = data;
			end
			if (bvalid && bready) begin
				check_value("bresp", 64'(expected_resp(addr)), 64'(bresp));
				wr_out = 1'b0;
			end else if (bvalid) begin
				held++;
				if (held >= hold)
					bready <= 1'b1;
			end
		end
	endtask

	task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, input int hold);
		int held;
		logic [63:0] t_lo;
		logic [63:0] t_hi;
		logic [63:0] exp_data;
		held = 0;
		t_hi = '0;
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= (hold == 0);
		do tick(); while (!arready);
		arvalid <= 1'b0;
		t_lo = mtime;
		rd_out = 1'b1;
		while (rd_out) begin
			tick();
			if (rvalid && held == 0)
				t_hi = mtime;
			if (rvalid && rready) begin
				if (addr == MTIME_ADDR) begin
					// wrap-safe window test
					if (rdata - t_lo > t_hi - t_lo)
						stop_run($sformatf("[ERROR] rdata %h outside mtime window %h to %h",
							rdata, t_lo, t_hi));
				end else begin
					exp_data = (addr == MTIMECMP_ADDR) ? m_cmp :
						(addr == MSIP_ADDR) ? 64'(m_msip) : 64'd0;
					check_value("rdata", exp_data, rdata);
				end
				check_value("rresp", 64'(expected_resp(addr)), 64'(rresp));
				rd_out = 1'b0;
			end else if (rvalid) begin
				held++;
				if (held >= hold)
					rready <= 1'b1;
			end
		end
	endtask

	initial begin
		int target;
		int hold;
		logic [63:0] data;
		logic [ADDR_WIDTH-1:0] addr;
		rng = 64'd45111;
		cycles = 0;
		m_msip = 1'b0;
		m_cmp = clint_pkg::MTIMECMP_RESET;
		{mt_valid, irq_valid, b_hold, r_hold, wr_out, rd_out} = '0;
		reset <= 1'b1;
		{awaddr, araddr, wdata} <= '0;
		{awvalid, wvalid, bready, arvalid, rready} <= '0;
		repeat (RESET_CYCLES) tick();
		reset <= 1'b0;
		tick();
		check_value("awready", 64'd0, 64'(awready));
		check_value("wready", 64'd0, 64'(wready));
		check_value("arready", 64'd0, 64'(arready));
		check_value("bvalid", 64'd0, 64'(bvalid));
		check_value("rvalid", 64'd0, 64'(rvalid));
		check_value("timer_irq", 64'd0, 64'(timer_irq));
		check_value("mtime", 64'd0, mtime);
		bus_read(MTIMECMP_ADDR, 0);
		bus_read(MSIP_ADDR, 2);
		for (int i = 2; i < NUM_TX; i++) begin
			target = int'(next_rand() % 64'd4);
			hold = int'(next_rand() % 64'd7);
			data = next_rand();
			case (target)
				0: addr = MSIP_ADDR;
				1: addr = MTIMECMP_ADDR;
				2: addr = MTIME_ADDR;
				default: addr = unmapped_addr();
			endcase
			if (target == 1 && data[63])
				data = mtime + (data & 64'h1f);   // compare close to the counter so irq toggles
			if (next_rand() % 64'd2 == 64'd0)
				bus_write(addr, data, hold);
			else
				bus_read(addr, hold);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: clint_timer.f
logic/clint_pkg.sv
logic/clint_bus_decode.sv
logic/clint_timer_core.sv
logic/clint_response.sv
logic/clint_timer.sv
bench/clint_timer_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module clint_timer_tb -f clint_timer.f --Mdir obj_dir
	./obj_dir/Vclint_timer_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "test incomplete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
